//--- rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // memory map
    localparam logic [addr_w-1:0] ram_base  = 64'h0000_0000_0000_1000;
    localparam int                ram_bytes = 4096;
    localparam int                ram_words = 1024;  // 32-bit words
    localparam int                ram_idx_w = 10;
    localparam logic [addr_w-1:0] key_addr  = 64'h0000_0000_0000_8000;
    localparam logic [addr_w-1:0] uart_addr = 64'h0000_0000_0000_8008;

    // load/store access type
    // stores reuse codes 0..3 as sb, sh, sw, sd
    typedef enum logic [2:0] {
        ls_lb  = 3'd0,
        ls_lh  = 3'd1,
        ls_lw  = 3'd2,
        ls_ld  = 3'd3,
        ls_lbu = 3'd4,
        ls_lhu = 3'd5,
        ls_lwu = 3'd6
    } ls_type_e;

    // what the processor holds on the bus while an access is in flight
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        ls_type_e          ls_type;
    } bus_req_t;

    // one-hot region of the current address
    typedef struct packed {
        logic ram;
        logic key;
        logic uart;
        logic none;  // unmapped
    } region_sel_t;

    // command from the bus controller into the ram port
    typedef struct packed {
        logic [ram_idx_w-1:0] idx;
        logic [1:0]           byte_off;
        ls_type_e             ls_type;
        logic [data_w-1:0]    wdata;
        logic                 rd;  // single-cycle strobe
        logic                 wr;  // single-cycle strobe
    } ram_cmd_t;

endpackage

//--- rtl/bus_decoder.sv
module bus_decoder (
    input  logic [soc_bus_pkg::addr_w-1:0]    addr,
    output soc_bus_pkg::region_sel_t          sel,
    output logic [soc_bus_pkg::ram_idx_w-1:0] ram_idx,
    output logic [1:0]                        byte_off
);

    import soc_bus_pkg::*;

    logic [addr_w-1:0] ram_off;  // byte offset into the ram window
    logic              in_ram;
    logic              is_key;
    logic              is_uart;

    assign ram_off = addr - ram_base;

    // ram window is [ram_base, ram_base + ram_bytes)
    assign in_ram  = (addr >= ram_base) && (addr < ram_base + ram_bytes);
    assign is_key  = (addr == key_addr);
    assign is_uart = (addr == uart_addr);

    assign sel.ram  = in_ram;
    assign sel.key  = is_key;
    assign sel.uart = is_uart;
    assign sel.none = !(in_ram || is_key || is_uart);  // anything else

    // word index drops the two byte bits
    assign ram_idx  = ram_off[ram_idx_w+1:2];
    assign byte_off = addr[1:0];

endmodule

//--- rtl/ram_port.sv
module ram_port (
    input  logic                           CLOCK_50,
    input  soc_bus_pkg::ram_cmd_t          cmd,
    output logic [soc_bus_pkg::data_w-1:0] rdata,
    output logic                           ram_done
);

    import soc_bus_pkg::*;

    logic [31:0] mem [0:ram_words-1];

    logic                 is_double;
    logic                 hi_rd;       // second beat of ld
    logic                 hi_wr;       // second beat of sd
    logic                 hi_beat;
    logic [ram_idx_w-1:0] acc_idx;
    logic [3:0]           lane_en;
    logic [31:0]          lane_word;
    logic                 wr_en;
    logic [3:0]           wr_lanes;
    logic [31:0]          wr_word;
    logic [31:0]          rd_word;
    logic [31:0]          shifted;
    logic [data_w-1:0]    load_val;

    assign is_double = (cmd.ls_type == ls_ld);  // ld and sd share code 3
    assign hi_beat   = hi_rd || hi_wr;

    // the high word of a double lives in the next index
    assign acc_idx = hi_beat ? cmd.idx + 1'b1 : cmd.idx;

    // lanes touched by a single-word store
    always_comb begin
        case (cmd.ls_type)
            ls_lb: begin
                lane_en   = 4'b0001 << cmd.byte_off;
                lane_word = cmd.wdata[31:0] << {cmd.byte_off, 3'b000};
            end
            ls_lh: begin
                lane_en   = 4'b0011 << cmd.byte_off;
                lane_word = cmd.wdata[31:0] << {cmd.byte_off, 3'b000};
            end
            default: begin  // sw, low half of sd
                lane_en   = 4'b1111;
                lane_word = cmd.wdata[31:0];
            end
        endcase
    end

    assign wr_en    = cmd.wr || hi_wr;
    assign wr_lanes = hi_wr ? 4'b1111 : lane_en;
    assign wr_word  = hi_wr ? cmd.wdata[63:32] : lane_word;

    // load path
    assign rd_word = mem[acc_idx];
    assign shifted = rd_word >> {cmd.byte_off, 3'b000};

    always_comb begin
        case (cmd.ls_type)
            ls_lb:   load_val = {{(data_w-8){shifted[7]}}, shifted[7:0]};
            ls_lbu:  load_val = {{(data_w-8){1'b0}}, shifted[7:0]};
            ls_lh:   load_val = {{(data_w-16){shifted[15]}}, shifted[15:0]};
            ls_lhu:  load_val = {{(data_w-16){1'b0}}, shifted[15:0]};
            ls_lw:   load_val = {{(data_w-32){shifted[31]}}, shifted};
            default: load_val = {{(data_w-32){1'b0}}, shifted};  // lwu, low half of ld
        endcase
    end

    // byte-lane array write
    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_lanes[b]) begin
                    mem[acc_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    // read data register
    always_ff @(posedge CLOCK_50) begin
        if (hi_rd) begin
            rdata[63:32] <= rd_word;
        end else if (cmd.rd) begin
            rdata <= load_val;
        end
    end

    // double beat state and the done pulse
    always_ff @(posedge CLOCK_50) begin
        hi_rd    <= cmd.rd && is_double;
        hi_wr    <= cmd.wr && is_double;
        ram_done <= ((cmd.rd || cmd.wr) && !is_double) || hi_beat;
    end

endmodule

//--- rtl/bus_controller.sv
module bus_controller (
    input  logic                              CLOCK_50,
    input  logic                              KEY0,
    input  soc_bus_pkg::bus_req_t             bus_req,
    input  logic                              bus_read_enable,
    input  logic                              bus_write_enable,
    input  soc_bus_pkg::region_sel_t          sel,
    input  logic [soc_bus_pkg::ram_idx_w-1:0] ram_idx,
    input  logic [1:0]                        byte_off,
    input  logic [soc_bus_pkg::data_w-1:0]    ram_rdata,
    input  logic                              ram_done,
    input  logic [7:0]                        key_data,
    output logic [soc_bus_pkg::addr_w-1:0]    req_addr,
    output soc_bus_pkg::ram_cmd_t             ram_cmd,
    output logic [soc_bus_pkg::data_w-1:0]    bus_read_data,
    output logic                              bus_read_done,
    output logic                              bus_write_done,
    output logic [7:0]                        uart_data,
    output logic                              uart_strobe
);

    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_decode,  // registered address is being decoded
        st_ram      // waiting on ram_done
    } ctrl_state_e;

    ctrl_state_e state;
    bus_req_t    req_q;
    logic        is_read;
    logic        ram_rd;
    logic        ram_wr;
    logic        start;

    assign start = bus_read_enable || bus_write_enable;

    // request stays put until the next enable
    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && start) begin
            req_q <= bus_req;
        end
    end

    assign req_addr  = req_q.addr;
    assign uart_data = req_q.wdata[7:0];

    // ram command with index and offset straight from the decoder
    assign ram_cmd.idx      = ram_idx;
    assign ram_cmd.byte_off = byte_off;
    assign ram_cmd.ls_type  = req_q.ls_type;
    assign ram_cmd.wdata    = req_q.wdata;
    assign ram_cmd.rd       = ram_rd;
    assign ram_cmd.wr       = ram_wr;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_idle;
            is_read        <= 1'b0;
            ram_rd         <= 1'b0;
            ram_wr         <= 1'b0;
            bus_read_data  <= '0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            uart_strobe    <= 1'b0;
        end else begin
            ram_rd      <= 1'b0;  // strobes last one cycle
            ram_wr      <= 1'b0;
            uart_strobe <= 1'b0;

            case (state)
                st_idle: begin
                    if (start) begin
                        is_read <= bus_read_enable;
                        if (bus_read_enable) bus_read_done <= 1'b0;
                        if (bus_write_enable) bus_write_done <= 1'b0;
                        state <= st_decode;
                    end
                end

                st_decode: begin
                    if (sel.ram) begin
                        ram_rd <= is_read;
                        ram_wr <= !is_read;
                        state  <= st_ram;
                    end else begin
                        // key, console and unmapped finish here
                        if (is_read) begin
                            bus_read_data <= sel.key ? {{(data_w-8){1'b0}}, key_data} : '0;
                            bus_read_done <= 1'b1;
                        end else begin
                            uart_strobe    <= sel.uart;  // key store is dropped
                            bus_write_done <= 1'b1;
                        end
                        state <= st_idle;
                    end
                end

                st_ram: begin
                    if (ram_done) begin
                        if (is_read) begin
                            bus_read_data <= ram_rdata;
                            bus_read_done <= 1'b1;
                        end else begin
                            bus_write_done <= 1'b1;
                        end
                        state <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- rtl/key_irq.sv
module key_irq (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_ascii,
    input  logic       key_pressed,  // one-cycle pulse
    input  logic       irq_ack,
    output logic [7:0] key_data,
    output logic [3:0] irq_vector
);

    logic key_valid;

    assign key_valid = key_pressed && (key_ascii != 8'd0);

    // keeps the last byte seen even when it is zero
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_data <= 8'd0;
        end else if (key_pressed) begin
            key_data <= key_ascii;
        end
    end

    // single source, so the vector is just 0 or 1
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else begin
            if (key_valid) begin
                irq_vector <= 4'd1;
            end
            if (irq_vector != 4'd0 && irq_ack) begin
                irq_vector <= 4'd0;  // ack wins over a press in the same cycle
            end
        end
    end

endmodule

//--- rtl/soc_bus_top.sv
module soc_bus_top (
    input  logic                           CLOCK_50,
    input  logic                           KEY0,
    input  soc_bus_pkg::bus_req_t          bus_req,
    input  logic                           bus_read_enable,
    input  logic                           bus_write_enable,
    output logic [soc_bus_pkg::data_w-1:0] bus_read_data,
    output logic                           bus_read_done,
    output logic                           bus_write_done,
    input  logic [7:0]                     key_ascii,
    input  logic                           key_pressed,
    output logic [3:0]                     irq_vector,
    input  logic                           irq_ack,
    output logic [7:0]                     uart_data,
    output logic                           uart_strobe
);

    import soc_bus_pkg::*;

    logic [addr_w-1:0]    req_addr;
    region_sel_t          sel;
    logic [ram_idx_w-1:0] ram_idx;
    logic [1:0]           byte_off;
    ram_cmd_t             ram_cmd;
    logic [data_w-1:0]    ram_rdata;
    logic                 ram_done;
    logic [7:0]           key_data;

    bus_controller i_bus_controller (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_req          (bus_req),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .sel              (sel),
        .ram_idx          (ram_idx),
        .byte_off         (byte_off),
        .ram_rdata        (ram_rdata),
        .ram_done         (ram_done),
        .key_data         (key_data),
        .req_addr         (req_addr),
        .ram_cmd          (ram_cmd),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .uart_data        (uart_data),
        .uart_strobe      (uart_strobe)
    );

    // decodes the latched address, not the live one
    bus_decoder i_bus_decoder (
        .addr     (req_addr),
        .sel      (sel),
        .ram_idx  (ram_idx),
        .byte_off (byte_off)
    );

    ram_port i_ram_port (
        .CLOCK_50 (CLOCK_50),
        .cmd      (ram_cmd),
        .rdata    (ram_rdata),
        .ram_done (ram_done)
    );

    key_irq i_key_irq (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_ascii   (key_ascii),
        .key_pressed (key_pressed),
        .irq_ack     (irq_ack),
        .key_data    (key_data),
        .irq_vector  (irq_vector)
    );

endmodule

//--- dv/tb_soc_bus.sv
module tb_soc_bus;

    import soc_bus_pkg::*;

    logic              CLOCK_50;
    logic              KEY0;
    bus_req_t          bus_req;
    logic              bus_read_enable;
    logic              bus_write_enable;
    logic [data_w-1:0] bus_read_data;
    logic              bus_read_done;
    logic              bus_write_done;
    logic [7:0]        key_ascii;
    logic              key_pressed;
    logic [3:0]        irq_vector;
    logic              irq_ack;
    logic [7:0]        uart_data;
    logic              uart_strobe;

    logic [7:0]  model_mem [0:ram_bytes-1];  // byte image of the ram window
    byte         op_a   [0:63];
    logic [2:0]  type_a [0:63];
    logic [63:0] addr_a [0:63];
    logic [63:0] data_a [0:63];
    logic [63:0] exp_a  [0:63];
    int          n_ops;
    int          check_cnt = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;
    int          uart_cnt = 0;
    logic [7:0]  uart_last;
    logic [31:0] rng;

    soc_bus_top i_soc_bus_top (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_req          (bus_req),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .key_ascii        (key_ascii),
        .key_pressed      (key_pressed),
        .irq_vector       (irq_vector),
        .irq_ack          (irq_ack),
        .uart_data        (uart_data),
        .uart_strobe      (uart_strobe)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, other_cnt);
    endtask

    always @(posedge CLOCK_50) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            other_cnt++;
            $display("Timeout: the bus did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // console monitor
    always @(posedge CLOCK_50) begin
        if (uart_strobe) begin
            uart_cnt++;
            uart_last = uart_data;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input logic [63:0] a);
        return a[31:0] ^ {a[15:0], a[31:16]} ^ a[63:32] ^ 32'h6b8b_4567;
    endfunction

    // little-endian gather, then sign extend for lb, lh, lw
    function automatic logic [63:0] predict_load(input logic [2:0] t, input logic [11:0] off);
        logic [63:0] v;
        int          size;
        v    = '0;
        size = 1 << t[1:0];
        for (int i = 0; i < size; i++) begin
            v[8*i +: 8] = model_mem[off + i];
        end
        if (t < 3 && size < 8 && v[8*size-1]) v = v | (~64'd0 << (8 * size));
        return v;
    endfunction

    task automatic load_ops(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [2:0]  t;
        logic [63:0] a;
        logic [63:0] d;
        logic [63:0] e;
        ok    = 1'b0;
        n_ops = 0;
        fd    = $fopen("dv/bus_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin  // skip header lines
                    n = $sscanf(line, "%c %h %h %h %h", op, t, a, d, e);
                    if (n == 5 && n_ops < 64) begin
                        op_a[n_ops]   = op;
                        type_a[n_ops] = t;
                        addr_a[n_ops] = a;
                        data_a[n_ops] = d;
                        exp_a[n_ops]  = e;
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
            ok = (n_ops > 0);
        end
    endtask

    // one access by the bus rule that returns once both dones are high again
    task automatic bus_access(input logic wr, input logic [2:0] t, input logic [63:0] a,
                              input logic [63:0] d, output logic [63:0] rd);
        @(posedge CLOCK_50);
        bus_req.addr     <= a;
        bus_req.wdata    <= d;
        bus_req.ls_type  <= ls_type_e'(t);
        bus_write_enable <= wr;
        bus_read_enable  <= !wr;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        bus_read_enable  <= 1'b0;
        @(negedge CLOCK_50);
        while (!(bus_read_done && bus_write_done)) @(negedge CLOCK_50);
        rd = bus_read_data;
    endtask

    task automatic store_op(input logic [2:0] t, input logic [63:0] a, input logic [63:0] d);
        logic [63:0] unused;
        logic [11:0] off;
        int          exp_cnt;
        uart_cnt = 0;
        bus_access(1'b1, t, a, d, unused);
        // strobe is counted on the edge after done, the extra edge catches a long one
        repeat (2) @(negedge CLOCK_50);
        exp_cnt = (a == uart_addr) ? 1 : 0;
        check_cnt++;
        if (uart_cnt != exp_cnt) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: store to %h gave %0d console strobes, expected %0d",
                     $time, a, uart_cnt, exp_cnt);
        end
        if (exp_cnt == 1 && uart_last !== d[7:0]) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: console byte %h, expected %h", $time, uart_last, d[7:0]);
        end
        if (a >= ram_base && a < ram_base + ram_bytes) begin
            off = a - ram_base;
            for (int i = 0; i < (1 << t[1:0]); i++) begin
                model_mem[off + i] = d[8*i +: 8];
            end
        end
    endtask

    task automatic load_op(input logic [2:0] t, input logic [63:0] a, input logic [63:0] exp);
        logic [63:0] got;
        bus_access(1'b0, t, a, 64'd0, got);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: load type %0d at %h returned %h, expected %h",
                     $time, t, a, got, exp);
        end
    endtask

    // press when is_ack is 0, acknowledge otherwise
    task automatic key_event(input logic is_ack, input logic [7:0] ascii, input logic [3:0] exp);
        @(posedge CLOCK_50);
        key_ascii   <= ascii;
        key_pressed <= !is_ack;
        irq_ack     <= is_ack;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        irq_ack     <= 1'b0;
        @(negedge CLOCK_50);
        check_cnt++;
        if (irq_vector !== exp) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: irq_vector %0d, expected %0d", $time, irq_vector, exp);
        end
    endtask

    task automatic run_file();
        for (int k = 0; k < n_ops; k++) begin
            case (op_a[k])
                "W":      store_op(type_a[k], addr_a[k], data_a[k]);
                "R", "U": load_op(type_a[k], addr_a[k], exp_a[k]);
                "K":      key_event(1'b0, data_a[k][7:0], exp_a[k][3:0]);
                "A":      key_event(1'b1, 8'd0, exp_a[k][3:0]);
                default: begin
                    other_cnt++;
                    $display("Error: unknown operation %c in stimulus entry %0d", op_a[k], k);
                end
            endcase
        end
    endtask

    task automatic random_pairs();
        logic [1:0]  st;
        logic [2:0]  lt;
        logic [11:0] off;
        logic [11:0] loff;
        logic [63:0] d;
        for (int i = 0; i < 200; i++) begin
            rng = xorshift(rng);
            st  = rng[1:0];
            rng = xorshift(rng);
            off = rng[11:0] & ~((12'd1 << st) - 12'd1);  // natural alignment
            rng = xorshift(rng);
            d[31:0] = rng;
            rng = xorshift(rng);
            d[63:32] = rng;
            store_op({1'b0, st}, ram_base + off, d);
            rng  = xorshift(rng);
            lt   = rng % 7;
            loff = off & ~((12'd1 << lt[1:0]) - 12'd1);
            load_op(lt, ram_base + loff, predict_load(lt, loff));
        end
    endtask

    initial begin
        bit          ok;
        logic [63:0] a;
        KEY0             = 1'b0;
        bus_req          = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_ascii        = 8'd0;
        key_pressed      = 1'b0;
        irq_ack          = 1'b0;
        rng              = 32'd38984;
        load_ops(ok);
        cycle_limit = 16 + 20 * (ram_words + n_ops + 400 + 1);
        if (!ok) begin
            other_cnt++;
            $display("Error: no operations could be read from dv/bus_input.txt");
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            repeat (16) @(posedge CLOCK_50);
            KEY0 <= 1'b1;
            @(negedge CLOCK_50);
            check_cnt++;
            if (bus_read_done !== 1'b1 || bus_write_done !== 1'b1 || irq_vector !== 4'd0 ||
                uart_strobe !== 1'b0 || bus_read_data !== '0) begin
                mismatch_cnt++;
                $display("Mismatch at %0t: outputs after reset are not at their idle values",
                         $time);
            end
            for (int w = 0; w < ram_words; w++) begin  // known contents for the model
                a = ram_base + 4 * w;
                store_op(3'd2, a, {32'd0, fill_word(a)});
            end
            run_file();
            random_pairs();
            print_counts();
            if (mismatch_cnt == 0 && other_cnt == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

//--- project.f
rtl/soc_bus_pkg.sv
rtl/bus_decoder.sv
rtl/ram_port.sv
rtl/bus_controller.sv
rtl/key_irq.sv
rtl/soc_bus_top.sv
dv/tb_soc_bus.sv

//--- dv/bus_input.txt
# columns: op type addr data expect, all hex except op
# op: W store, R load, K key press, A irq ack, U unmapped load
W 2 1010 8091a2b3 0
R 0 1013 0 ffffffffffffff80
R 4 1011 0 a2
R 1 1012 0 ffffffffffff8091
R 5 1010 0 a2b3
R 6 1010 0 8091a2b3
W 1 1012 1234 0
R 2 1010 0 1234a2b3
W 3 1020 fedcba9876543210 0
R 3 1020 0 fedcba9876543210
R 2 1024 0 fffffffffedcba98
R 6 1020 0 76543210
W 2 8008 4d 0
K 0 0 41 1
R 4 8000 0 41
A 0 0 0 0
K 0 0 0 0
U 3 2000 0 0
W 2 2010 deadbeef 0
R 6 1010 0 1234a2b3
